/* conv_pkg.sv */
`default_nettype none

package conv_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int NUM_MAC   = 2;                 // Peer MAC units.
    localparam int MAC_IDX_W = $clog2(NUM_MAC);   // Unit index width.
    localparam int ADDR_W    = 6;
    localparam int MEM_DEPTH = 64;
    localparam int DATA_W    = 16;                // One Q8.8 value.
    localparam int FRAC_W    = 8;
    localparam int CNT_W     = 16;

    // Data in the upper half, weight in the lower half.
    localparam int PAIR_W    = 2 * DATA_W;

    // Saturation limits.
    localparam logic [DATA_W-1:0] SAT_MAX = 16'h7FFF;
    localparam logic [DATA_W-1:0] SAT_MIN = 16'h8000;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // MAC controller states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,   // Waiting for start.
        ST_FETCH = 3'd1,   // Request and read one pair.
        ST_MULT  = 3'd2,   // Product in flight.
        ST_ACC   = 3'd3,   // Running sum update.
        ST_BIAS  = 3'd4,   // Bias add.
        ST_DONE  = 3'd5    // Result held.
    } mac_state_t;

endpackage : conv_pkg

`default_nettype wire

/* fx_mult.sv */
`default_nettype none

module fx_mult (
    input  wire                          clk,
    input  wire                          rst,
    input  wire  [conv_pkg::DATA_W-1:0]  a,
    input  wire  [conv_pkg::DATA_W-1:0]  b,
    input  wire                          nd,
    output logic [conv_pkg::DATA_W-1:0]  result,
    output logic                         rdy
);
    import conv_pkg::*;

    logic signed [2*DATA_W-1:0] prod_q;
    logic signed [2*DATA_W-1:0] prod_shr;
    logic        [DATA_W:0]     prod_top;
    logic        [DATA_W-1:0]   prod_sat;
    logic                       busy_q;

    // Drop the fraction, then clamp to 16 bits.
    assign prod_shr = prod_q >>> FRAC_W;
    assign prod_top = prod_shr[2*DATA_W-1:DATA_W-1];
    assign prod_sat = (&prod_top || ~|prod_top) ? prod_shr[DATA_W-1:0] :
                      (prod_shr[2*DATA_W-1] ? SAT_MIN : SAT_MAX);

    always_ff @(posedge clk) begin
        if (nd)
            prod_q <= $signed(a) * $signed(b);   // Full product.
        if (busy_q)
            result <= prod_sat;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q <= 1'b0;
            rdy    <= 1'b0;
        end else begin
            busy_q <= nd;
            rdy    <= busy_q;
        end
    end

    // One operation at a time.
    a_no_overlap: assert property (@(posedge clk) disable iff (rst) nd |-> !busy_q);

endmodule : fx_mult

`default_nettype wire

/* fx_accum.sv */
`default_nettype none

module fx_accum (
    input  wire                          clk,
    input  wire                          rst,
    input  wire  [conv_pkg::DATA_W-1:0]  a,
    input  wire  [conv_pkg::DATA_W-1:0]  b,
    input  wire                          nd,
    output logic [conv_pkg::DATA_W-1:0]  result,
    output logic                         rdy
);
    import conv_pkg::*;

    logic [DATA_W-1:0] sum;
    logic              ovf;

    assign sum = a + b;

    // Same operand signs but a flipped sum sign.
    assign ovf = (a[DATA_W-1] == b[DATA_W-1]) && (sum[DATA_W-1] != a[DATA_W-1]);

    always_ff @(posedge clk) begin
        if (nd) begin
            if (ovf)
                result <= a[DATA_W-1] ? SAT_MIN : SAT_MAX;
            else
                result <= sum;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            rdy <= 1'b0;
        else
            rdy <= nd;   // Fixed single-cycle latency.
    end

endmodule : fx_accum

`default_nettype wire

/* cmac.sv */
`default_nettype none

module cmac (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          start,
    input  wire  [conv_pkg::CNT_W-1:0]   op_num,
    input  wire  [conv_pkg::ADDR_W-1:0]  base_addr,
    input  wire  [conv_pkg::DATA_W-1:0]  bias,
    output logic                         mem_req,
    output logic [conv_pkg::ADDR_W-1:0]  mem_addr,
    input  wire                          mem_gnt,
    input  wire  [conv_pkg::PAIR_W-1:0]  rd_data,
    output logic [conv_pkg::DATA_W-1:0]  result,
    output logic                         conv_valid
);
    import conv_pkg::*;

    mac_state_t        state;
    mac_state_t        next_state;

    logic [CNT_W-1:0]  remain_cnt;
    logic              rd_pending;   // Granted last cycle, data arrives now.
    logic [DATA_W-1:0] bias_q;
    logic [DATA_W-1:0] sum_q;
    logic [DATA_W-1:0] a_mult;
    logic [DATA_W-1:0] b_mult;
    logic [DATA_W-1:0] a_acc;
    logic [DATA_W-1:0] b_acc;
    logic              mult_nd;
    logic              mult_rdy;
    logic              acc_nd;
    logic              acc_rdy;
    logic [DATA_W-1:0] mult_result;
    logic [DATA_W-1:0] acc_result;

    logic start_ok;
    logic rd_capture;
    logic mult_done;
    logic acc_done;
    logic bias_done;
    logic last_pair;

    fx_mult fx_mult_i (
        .clk    (clk),
        .rst    (rst),
        .a      (a_mult),
        .b      (b_mult),
        .nd     (mult_nd),
        .result (mult_result),
        .rdy    (mult_rdy)
    );

    fx_accum fx_accum_i (
        .clk    (clk),
        .rst    (rst),
        .a      (a_acc),
        .b      (b_acc),
        .nd     (acc_nd),
        .result (acc_result),
        .rdy    (acc_rdy)
    );

    assign start_ok   = start && (state == ST_IDLE || state == ST_DONE);
    assign rd_capture = (state == ST_FETCH) && rd_pending;
    assign mult_done  = (state == ST_MULT) && mult_rdy;
    assign acc_done   = (state == ST_ACC) && acc_rdy;
    assign bias_done  = (state == ST_BIAS) && acc_rdy;
    assign last_pair  = (remain_cnt == '0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            state <= ST_IDLE;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE, ST_DONE: if (start) next_state = ST_FETCH;
            ST_FETCH:         if (rd_pending) next_state = ST_MULT;
            ST_MULT:          if (mult_rdy) next_state = ST_ACC;
            ST_ACC: begin
                if (acc_rdy)
                    next_state = last_pair ? ST_BIAS : ST_FETCH;
            end
            ST_BIAS:          if (acc_rdy) next_state = ST_DONE;
            default:          next_state = ST_IDLE;
        endcase
    end

    // Control and strobes.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_req    <= 1'b0;
            mem_addr   <= '0;
            rd_pending <= 1'b0;
            remain_cnt <= '0;
            mult_nd    <= 1'b0;
            acc_nd     <= 1'b0;
            result     <= '0;
            conv_valid <= 1'b0;
        end else begin
            mult_nd <= 1'b0;
            acc_nd  <= 1'b0;
            if (start_ok) begin
                remain_cnt <= op_num;
                mem_addr   <= base_addr;
                conv_valid <= 1'b0;
                mem_req    <= 1'b1;
            end
            if (state == ST_FETCH && mem_req && mem_gnt) begin
                mem_req    <= 1'b0;
                rd_pending <= 1'b1;
            end
            if (rd_capture) begin
                rd_pending <= 1'b0;
                mult_nd    <= 1'b1;
            end
            if (mult_done)
                acc_nd <= 1'b1;
            if (acc_done) begin
                if (last_pair) begin
                    acc_nd <= 1'b1;   // Bias add.
                end else begin
                    remain_cnt <= remain_cnt - 1'b1;
                    mem_addr   <= mem_addr + 1'b1;
                    mem_req    <= 1'b1;
                end
            end
            if (bias_done) begin
                result     <= acc_result[DATA_W-1] ? '0 : acc_result;   // ReLU.
                conv_valid <= 1'b1;
            end
        end
    end

    // Operands and running sum.
    always_ff @(posedge clk) begin
        if (start_ok) begin
            bias_q <= bias;
            sum_q  <= '0;
        end
        if (rd_capture) begin
            a_mult <= rd_data[PAIR_W-1:DATA_W];
            b_mult <= rd_data[DATA_W-1:0];
        end
        if (mult_done) begin
            a_acc <= sum_q;
            b_acc <= mult_result;
        end
        // Bias operands are staged on every pair and used only after the last.
        if (acc_done) begin
            sum_q <= acc_result;
            a_acc <= acc_result;
            b_acc <= bias_q;
        end
    end

    a_req_held: assert property (@(posedge clk) disable iff (rst)
        $fell(mem_req) |-> $past(mem_gnt));

    a_busy_start: assert property (@(posedge clk) disable iff (rst)
        (start && !(state inside {ST_IDLE, ST_DONE}) && !acc_done)
        |=> $stable(remain_cnt) && $stable(mem_addr));

endmodule : cmac

`default_nettype wire

/* operand_mem.sv */
`default_nettype none

module operand_mem (
    input  wire                          clk,
    input  wire                          wr_en,
    input  wire  [conv_pkg::ADDR_W-1:0]  wr_addr,
    input  wire  [conv_pkg::PAIR_W-1:0]  wr_data,
    input  wire                          rd_en,
    input  wire  [conv_pkg::ADDR_W-1:0]  rd_addr,
    output logic [conv_pkg::PAIR_W-1:0]  rd_data
);
    import conv_pkg::*;

    logic [PAIR_W-1:0] mem [MEM_DEPTH];

    // Write port.
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // Registered read, data one cycle after the grant.
    always_ff @(posedge clk) begin
        if (rd_en)
            rd_data <= mem[rd_addr];
    end

endmodule : operand_mem

`default_nettype wire

/* mem_arbiter.sv */
`default_nettype none

module mem_arbiter (
    input  wire                           clk,
    input  wire                           rst,
    input  wire  [conv_pkg::NUM_MAC-1:0]  req,
    input  wire  [conv_pkg::ADDR_W-1:0]   addr_in [conv_pkg::NUM_MAC],
    output logic [conv_pkg::NUM_MAC-1:0]  gnt,
    output logic                          rd_en,
    output logic [conv_pkg::ADDR_W-1:0]   rd_addr
);
    import conv_pkg::*;

    logic [MAC_IDX_W-1:0] ptr;   // Highest priority unit.
    logic [MAC_IDX_W-1:0] win;
    logic                 found;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Round-robin pick starting at the pointer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin : pick
        int idx;
        found = 1'b0;
        win   = ptr;
        for (int k = 0; k < NUM_MAC; k++) begin
            idx = (int'(ptr) + k) % NUM_MAC;
            if (!found && req[idx]) begin
                found = 1'b1;
                win   = MAC_IDX_W'(idx);
            end
        end
    end

    assign gnt     = found ? ({{(NUM_MAC-1){1'b0}}, 1'b1} << win) : '0;
    assign rd_en   = found;
    assign rd_addr = addr_in[win];

    // Pointer moves past the winner.
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            ptr <= '0;
        else if (found)
            ptr <= (win == MAC_IDX_W'(NUM_MAC - 1)) ? '0 : win + 1'b1;
    end

    a_gnt_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(gnt) && ((gnt & ~req) == '0));

endmodule : mem_arbiter

`default_nettype wire

/* conv_top.sv */
`default_nettype none

module conv_top (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          wr_en,
    input  wire  [conv_pkg::ADDR_W-1:0]  wr_addr,
    input  wire  [conv_pkg::PAIR_W-1:0]  wr_data,
    input  wire                          start      [conv_pkg::NUM_MAC],
    input  wire  [conv_pkg::CNT_W-1:0]   op_num     [conv_pkg::NUM_MAC],
    input  wire  [conv_pkg::ADDR_W-1:0]  base_addr  [conv_pkg::NUM_MAC],
    input  wire  [conv_pkg::DATA_W-1:0]  bias       [conv_pkg::NUM_MAC],
    output wire  [conv_pkg::DATA_W-1:0]  result     [conv_pkg::NUM_MAC],
    output wire                          conv_valid [conv_pkg::NUM_MAC]
);
    import conv_pkg::*;

    wire [NUM_MAC-1:0] mem_req;
    wire [NUM_MAC-1:0] mem_gnt;
    wire [ADDR_W-1:0]  mem_addr [NUM_MAC];
    wire               rd_en;
    wire [ADDR_W-1:0]  rd_addr;
    wire [PAIR_W-1:0]  rd_data;   // Broadcast to all units.

    operand_mem operand_mem_i (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    mem_arbiter mem_arbiter_i (
        .clk     (clk),
        .rst     (rst),
        .req     (mem_req),
        .addr_in (mem_addr),
        .gnt     (mem_gnt),
        .rd_en   (rd_en),
        .rd_addr (rd_addr)
    );

    for (genvar i = 0; i < NUM_MAC; i++) begin : g_mac
        cmac cmac_i (
            .clk        (clk),
            .rst        (rst),
            .start      (start[i]),
            .op_num     (op_num[i]),
            .base_addr  (base_addr[i]),
            .bias       (bias[i]),
            .mem_req    (mem_req[i]),
            .mem_addr   (mem_addr[i]),
            .mem_gnt    (mem_gnt[i]),
            .rd_data    (rd_data),
            .result     (result[i]),
            .conv_valid (conv_valid[i])
        );
    end

endmodule : conv_top

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    localparam int HALF_PERIOD = 10;   // Period of 20.
    localparam int RST_CYCLES  = 5;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule : tb_clock_gen

`default_nettype wire

/* conv_tb.sv */
`default_nettype none

module conv_tb;
    import conv_pkg::*;

    localparam int NUM_CASES = 8;
    localparam int LARGE_LO  = 48;   // Deliberately large operands.
    localparam int LARGE_HI  = 55;

    logic              clk;
    logic              rst;
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [PAIR_W-1:0] wr_data;
    logic              start      [NUM_MAC];
    logic [CNT_W-1:0]  op_num     [NUM_MAC];
    logic [ADDR_W-1:0] base_addr  [NUM_MAC];
    logic [DATA_W-1:0] bias       [NUM_MAC];
    wire  [DATA_W-1:0] result     [NUM_MAC];
    wire               conv_valid [NUM_MAC];

    // One stimulus table entry per unit and row.
    logic              case_go   [NUM_CASES][NUM_MAC];
    int                case_op   [NUM_CASES][NUM_MAC];
    int                case_base [NUM_CASES][NUM_MAC];
    logic [DATA_W-1:0] case_bias [NUM_CASES][NUM_MAC];

    logic [PAIR_W-1:0] mem_copy [MEM_DEPTH];   // Everything written to the DUT.
    logic [DATA_W-1:0] last_exp [NUM_MAC];
    logic              ran      [NUM_MAC];

    int   seed;
    int   cycle_cnt;
    int   cycle_limit;
    logic running;

    tb_clock_gen tb_clock_gen_i (
        .clk (clk),
        .rst (rst)
    );

    conv_top conv_top_i (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .start      (start),
        .op_num     (op_num),
        .base_addr  (base_addr),
        .bias       (bias),
        .result     (result),
        .conv_valid (conv_valid)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [DATA_W-1:0] clamp16(input int v);
        if (v > 32767)
            return 16'h7FFF;
        else if (v < -32768)
            return 16'h8000;
        else
            return 16'(v);
    endfunction

    function automatic logic [DATA_W-1:0] expected_result(input int op, input int base,
                                                          input logic [DATA_W-1:0] b);
        logic [DATA_W-1:0] acc;
        logic [DATA_W-1:0] prod;
        logic [PAIR_W-1:0] word;
        int                full;
        int                k;
        acc = '0;
        for (k = 0; k <= op; k++) begin
            word = mem_copy[ADDR_W'(base + k)];   // Address wraps like the counter.
            full = int'($signed(word[PAIR_W-1:DATA_W])) * int'($signed(word[DATA_W-1:0]));
            prod = clamp16(full >>> FRAC_W);
            acc  = clamp16(int'($signed(acc)) + int'($signed(prod)));
        end
        acc = clamp16(int'($signed(acc)) + int'($signed(b)));   // Bias last.
        return acc[DATA_W-1] ? '0 : acc;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            $display("tests failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic set_case(input int row,
                            input logic go0, input int op0, input int base0,
                            input logic [DATA_W-1:0] bias0,
                            input logic go1, input int op1, input int base1,
                            input logic [DATA_W-1:0] bias1);
        case_go[row][0]   = go0;
        case_op[row][0]   = op0;
        case_base[row][0] = base0;
        case_bias[row][0] = bias0;
        case_go[row][1]   = go1;
        case_op[row][1]   = op1;
        case_base[row][1] = base1;
        case_bias[row][1] = bias1;
    endtask

    task automatic fill_cases();
        set_case(0, 1'b1, 0, 3,  16'h0100, 1'b0, 0, 0,  16'h0000);   // Single pair.
        set_case(1, 1'b0, 0, 0,  16'h0000, 1'b1, 7, 10, 16'h0040);   // Run of pairs.
        set_case(2, 1'b1, 4, 20, 16'hC000, 1'b0, 0, 0,  16'h0000);   // Negative sum for ReLU.
        set_case(3, 1'b1, 7, 48, 16'h0000, 1'b0, 0, 0,  16'h0000);   // Saturation.
        set_case(4, 1'b1, 5, 30, 16'h0080, 1'b1, 5, 32, 16'hFF00);   // Overlapping.
        set_case(5, 1'b1, 9, 0,  16'h0020, 1'b1, 6, 40, 16'h0000);   // Separate.
        set_case(6, 1'b0, 0, 0,  16'h0000, 1'b1, 3, 52, 16'h7F00);
        set_case(7, 1'b1, 0, 63, 16'h0010, 1'b1, 2, 61, 16'h0000);
    endtask

    function automatic int timeout_limit();
        int total;
        int r;
        int u;
        total = 0;
        for (r = 0; r < NUM_CASES; r++) begin
            for (u = 0; u < NUM_MAC; u++)
                if (case_go[r][u])
                    total += (case_op[r][u] + 1) * 16;
            total += 50;
        end
        return total;
    endfunction

    task automatic init_inputs();
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        for (int u = 0; u < NUM_MAC; u++) begin
            start[u]     = 1'b0;
            op_num[u]    = '0;
            base_addr[u] = '0;
            bias[u]      = '0;
            last_exp[u]  = '0;
            ran[u]       = 1'b0;
        end
    endtask

    task automatic load_memory();
        logic [DATA_W-1:0] d;
        logic [DATA_W-1:0] w;
        int                a;
        for (a = 0; a < MEM_DEPTH; a++) begin
            if (a >= LARGE_LO && a <= LARGE_HI) begin
                d = a[0] ? 16'h8100 : 16'h7E00;   // About -127 or +126.
                w = 16'h4000 | 16'($random(seed) & 32'h0FFF);
                if (a[1])
                    w = -w;
            end else begin
                d = 16'($random(seed) % 1024);
                w = 16'($random(seed) % 512);
            end
            mem_copy[a] = {d, w};
            @(posedge clk);
            #1;
            wr_en   = 1'b1;
            wr_addr = ADDR_W'(a);
            wr_data = {d, w};
        end
        @(posedge clk);
        #1;
        wr_en = 1'b0;
    endtask

    function automatic logic all_valid(input int row);
        logic ok;
        int   u;
        ok = 1'b1;
        for (u = 0; u < NUM_MAC; u++)
            if (case_go[row][u] && !conv_valid[u])
                ok = 1'b0;
        return ok;
    endfunction

    task automatic apply_case(input int row);
        logic [DATA_W-1:0] exp_val;
        int                u;
        @(posedge clk);
        #1;
        for (u = 0; u < NUM_MAC; u++) begin
            start[u]     = case_go[row][u];
            op_num[u]    = CNT_W'(case_op[row][u]);
            base_addr[u] = ADDR_W'(case_base[row][u]);
            bias[u]      = case_bias[row][u];
        end
        @(posedge clk);
        #1;
        for (u = 0; u < NUM_MAC; u++) begin
            start[u] = 1'b0;
            if (case_go[row][u])   // Old result withdrawn.
                check_value($sformatf("conv_valid[%0d]", u), 32'd0, 32'(conv_valid[u]));
        end
        while (!all_valid(row)) begin
            @(posedge clk);
            #1;
        end
        for (u = 0; u < NUM_MAC; u++) begin
            if (case_go[row][u]) begin
                exp_val = expected_result(case_op[row][u], case_base[row][u],
                                          case_bias[row][u]);
                last_exp[u] = exp_val;
                ran[u]      = 1'b1;
            end
            if (ran[u]) begin
                check_value($sformatf("result[%0d]", u), 32'(last_exp[u]), 32'(result[u]));
                if (!case_go[row][u])   // Idle units hold their last result.
                    check_value($sformatf("conv_valid[%0d]", u), 32'd1, 32'(conv_valid[u]));
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : main
        running   = 1'b0;
        cycle_cnt = 0;
        seed      = 29;
        init_inputs();
        fill_cases();
        cycle_limit = timeout_limit();
        wait (rst == 1'b0);
        for (int u = 0; u < NUM_MAC; u++) begin
            check_value($sformatf("result[%0d]", u), 32'd0, 32'(result[u]));
            check_value($sformatf("conv_valid[%0d]", u), 32'd0, 32'(conv_valid[u]));
        end
        load_memory();
        running = 1'b1;
        for (int r = 0; r < NUM_CASES; r++)
            apply_case(r);
        $display("all tests passed");
        $finish;
    end

    // Cycle budget for the table.
    initial begin : watchdog
        wait (running == 1'b1);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("tests failed");
        $fatal(1, "simulation timed out after %0d cycles", cycle_cnt);
    end

endmodule : conv_tb

`default_nettype wire

/* all.f */
conv_pkg.sv
fx_mult.sv
fx_accum.sv
cmac.sv
operand_mem.sv
mem_arbiter.sv
conv_top.sv
tb_clock_gen.sv
conv_tb.sv

/* Makefile */
# Verilator build and run for the convolution engine testbench.

VERILATOR ?= verilator
TOP       ?= conv_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
JOBS      ?= 4

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test verdict.
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
